// File: demodRegPkg.sv
// Processor register map shared by the register block, the selector and the top level
// Word addresses on a 16-bit data bus, and unused addresses read as zero
`default_nettype none

package demodRegPkg;

    // ******************************
    // Bus geometry
    // ******************************
    localparam int regAddrWidth = 4;
    localparam int regDataWidth = 16;

    // Register addresses
    localparam logic [regAddrWidth-1:0] addrVersion   = 4'd0;
    localparam logic [regAddrWidth-1:0] addrImageType = 4'd1;
    localparam logic [regAddrWidth-1:0] addrClockLo   = 4'd2;
    localparam logic [regAddrWidth-1:0] addrClockHi   = 4'd3;
    localparam logic [regAddrWidth-1:0] addrMode      = 4'd4;

    // Read-only identification
    localparam logic [regDataWidth-1:0] versionNumber    = 16'h0194;
    localparam logic [regDataWidth-1:0] legacyDemodImage = 16'h0003;

    // ******************************
    // Demodulator modes
    // ******************************
    localparam int modeWidth = 5;
    localparam logic [modeWidth-1:0] modeAm     = 5'd0;
    localparam logic [modeWidth-1:0] modeFm     = 5'd1;
    localparam logic [modeWidth-1:0] mode2Fsk   = 5'd2;
    localparam logic [modeWidth-1:0] modeAqpsk  = 5'd3;
    localparam logic [modeWidth-1:0] modeAuqpsk = 5'd4;
    localparam logic [modeWidth-1:0] modeMultih = 5'd5;

    localparam int clockCountWidth = 32;

endpackage

`default_nettype wire

// File: demodDataPkg.sv
// Sample formats on the demodulator output side
// A DAC takes the top 14 bits of an 18-bit sample and drops 4 fraction bits
`default_nettype none

package demodDataPkg;

    // ******************************
    // Widths and channel count
    // ******************************
    localparam int sampleWidth = 18;
    localparam int dacWidth    = 14;
    localparam int fracWidth   = 4;
    localparam int numDacs     = 3;

    // Same 18 bits seen as a whole sample or as DAC code over fraction
    typedef union packed {
        logic [sampleWidth-1:0] word;
        struct packed {
            logic [dacWidth-1:0]  code;
            logic [fracWidth-1:0] frac;
        } dac;
    } dacSample_t;

endpackage

`default_nettype wire

// File: dacChannel.sv
// One DAC output register, loaded with the top 14 bits of a sample on sync
// Code holds its value while the sync strobe is low
`timescale 1ns/1ps
`default_nettype none

module dacChannel (
    input  wire                                   clk,
    input  wire                                   clockCounterEn,
    input  wire  demodDataPkg::dacSample_t        sample,
    input  wire                                   sampleSync,
    output logic                                  dacSync,
    output logic [demodDataPkg::dacWidth-1:0]     dacD
);

    // Sync delayed to line up with the loaded code
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacSync <= 1'b0;
            dacD    <= '0;
        end else begin
            dacSync <= sampleSync;
            if (sampleSync) begin
                dacD <= sample.dac.code;
            end
        end
    end

endmodule

`default_nettype wire

// File: regBlock.sv
// Register space behind a four-phase req/ack access in the clk domain
// Master keeps regWrite, regAddr and regWrData stable while regReq is high
// Clock hold is only valid after a read of the low counter word
`timescale 1ns/1ps
`default_nettype none

module regBlock (
    input  wire                                      clk,
    input  wire                                      clockCounterEn,
    input  wire                                      regReq,
    input  wire                                      regWrite,
    input  wire  [demodRegPkg::regAddrWidth-1:0]     regAddr,
    input  wire  [demodRegPkg::regDataWidth-1:0]     regWrData,
    output logic [demodRegPkg::regDataWidth-1:0]     regRdData,
    output logic                                     regAck,
    output logic [demodRegPkg::modeWidth-1:0]        demodMode
);

    logic                                        accept;
    logic                                        wrMode;
    logic                                        wrClockLo;
    logic                                        rdClockLo;
    logic [demodRegPkg::clockCountWidth-1:0]     clockCount;
    logic [demodRegPkg::clockCountWidth-1:0]     clockHold;
    logic [demodRegPkg::regDataWidth-1:0]        readMux;

    // ******************************
    // Handshake
    // ******************************
    // One access per regReq pulse
    assign accept    = regReq && !regAck;
    assign wrMode    = accept && regWrite && (regAddr == demodRegPkg::addrMode);
    assign wrClockLo = accept && regWrite && (regAddr == demodRegPkg::addrClockLo);
    assign rdClockLo = accept && !regWrite && (regAddr == demodRegPkg::addrClockLo);

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            regAck <= 1'b0;
        end else if (accept) begin
            regAck <= 1'b1;
        end else if (!regReq) begin
            regAck <= 1'b0;
        end
    end

    // Mode register
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode <= demodRegPkg::modeAm;
        end else if (wrMode) begin
            demodMode <= regWrData[demodRegPkg::modeWidth-1:0];
        end
    end

    // ******************************
    // Free-running clock counter
    // ******************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            clockCount <= '0;
        end else if (wrClockLo) begin
            clockCount <= '0;
        end else begin
            clockCount <= clockCount + 1'b1;
        end
    end

    // Edges seen after the clearing edge, up to the reading edge
    always_ff @(posedge clk) begin
        if (rdClockLo) begin
            clockHold <= clockCount;
        end
    end

    // Low half comes straight from the counter since the hold loads on the same edge
    always_comb begin
        readMux = '0;
        case (regAddr)
            demodRegPkg::addrVersion:   readMux = demodRegPkg::versionNumber;
            demodRegPkg::addrImageType: readMux = demodRegPkg::legacyDemodImage;
            demodRegPkg::addrClockLo:   readMux = clockCount[demodRegPkg::regDataWidth-1:0];
            demodRegPkg::addrClockHi: begin
                readMux = clockHold[demodRegPkg::clockCountWidth-1:demodRegPkg::regDataWidth];
            end
            demodRegPkg::addrMode: begin
                readMux = {{(demodRegPkg::regDataWidth - demodRegPkg::modeWidth){1'b0}},
                           demodMode};
            end
            default: readMux = '0;
        endcase
    end

    // Read data held steady while regAck is high
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            regRdData <= '0;
        end else if (accept && !regWrite) begin
            regRdData <= readMux;
        end
    end

endmodule

`default_nettype wire

// File: outputSelect.sv
// Per-mode choice between legacy demod and multi-h loop outputs
// Every output is registered once, so all paths have one cycle of latency
`timescale 1ns/1ps
`default_nettype none

module outputSelect (
    input  wire                                          clk,
    input  wire                                          clockCounterEn,
    input  wire  [demodRegPkg::modeWidth-1:0]            demodMode,
    input  wire  demodDataPkg::dacSample_t               legacyDacData [demodDataPkg::numDacs],
    input  wire  [demodDataPkg::numDacs-1:0]             legacyDacSync,
    input  wire  demodDataPkg::dacSample_t               multihDacData [demodDataPkg::numDacs],
    input  wire  [demodDataPkg::numDacs-1:0]             multihDacSync,
    input  wire  [demodDataPkg::numDacs-1:0]             multihDacEn,
    input  wire  [demodDataPkg::sampleWidth-1:0]         legacyTrellisI,
    input  wire  [demodDataPkg::sampleWidth-1:0]         legacyTrellisQ,
    input  wire                                          legacyTrellisSymEn,
    input  wire                                          legacySym2xEn,
    input  wire  [demodDataPkg::sampleWidth-1:0]         multihTrellisI,
    input  wire  [demodDataPkg::sampleWidth-1:0]         multihTrellisQ,
    input  wire                                          multihSymEn,
    input  wire                                          multihSym2xEn,
    input  wire                                          iBit,
    input  wire                                          qBit,
    input  wire                                          auBit,
    input  wire                                          iSymEn,
    input  wire                                          carrierLock,
    input  wire                                          multihLock,
    input  wire                                          bitsyncLock,
    output demodDataPkg::dacSample_t                     selDacData [demodDataPkg::numDacs],
    output logic [demodDataPkg::numDacs-1:0]             selDacSync,
    output logic [demodDataPkg::sampleWidth-1:0]         iTrellis,
    output logic [demodDataPkg::sampleWidth-1:0]         qTrellis,
    output logic                                         trellisSymEn,
    output logic                                         trellisSym2xEn,
    output logic                                         iData,
    output logic                                         qData,
    output logic                                         dataSymEn,
    output logic                                         dataSym2xEn,
    output logic                                         legacyBit,
    output logic                                         demodNLock,
    output logic                                         bsyncNLock
);

    logic                               multihMode;
    logic                               fmModes;
    logic                               aModes;
    logic [demodDataPkg::numDacs-1:0]   useMultih;

    // ******************************
    // Mode groups
    // ******************************
    assign multihMode = (demodMode == demodRegPkg::modeMultih);
    assign fmModes    = (demodMode == demodRegPkg::modeFm) ||
                        (demodMode == demodRegPkg::mode2Fsk);
    assign aModes     = (demodMode == demodRegPkg::modeAqpsk) ||
                        (demodMode == demodRegPkg::modeAuqpsk);

    // Multi-h loop owns a DAC only when it enables that channel
    assign useMultih = multihDacEn & {demodDataPkg::numDacs{multihMode}};

    // DAC sample words
    always_ff @(posedge clk) begin
        for (int k = 0; k < demodDataPkg::numDacs; k++) begin
            selDacData[k].word <= useMultih[k] ? multihDacData[k].word
                                               : legacyDacData[k].word;
        end
    end

    // ******************************
    // Strobes, trellis, bits, locks
    // ******************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            selDacSync     <= '0;
            iTrellis       <= '0;
            qTrellis       <= '0;
            trellisSymEn   <= 1'b0;
            trellisSym2xEn <= 1'b0;
            iData          <= 1'b0;
            qData          <= 1'b0;
            dataSymEn      <= 1'b0;
            dataSym2xEn    <= 1'b0;
            legacyBit      <= 1'b0;
            demodNLock     <= 1'b1;
            bsyncNLock     <= 1'b1;
        end else begin
            selDacSync     <= (multihDacSync & useMultih) | (legacyDacSync & ~useMultih);
            iTrellis       <= multihMode ? multihTrellisI : legacyTrellisI;
            qTrellis       <= multihMode ? multihTrellisQ : legacyTrellisQ;
            trellisSymEn   <= multihMode ? multihSymEn : legacyTrellisSymEn;
            trellisSym2xEn <= multihMode ? multihSym2xEn : legacySym2xEn;
            // FM discriminator output has the opposite sense
            iData          <= fmModes ? ~iBit : iBit;
            qData          <= aModes ? auBit : qBit;
            dataSymEn      <= iSymEn;
            dataSym2xEn    <= legacySym2xEn;
            legacyBit      <= iBit;
            demodNLock     <= multihMode ? ~multihLock : ~carrierLock;
            bsyncNLock     <= ~bitsyncLock;
        end
    end

endmodule

`default_nettype wire

// File: legacyDemodTop.sv
// Output and control side of the legacy demodulator
// Demod core and multi-h loop outputs arrive as ports on the clk domain
// DAC ports change two cycles after a qualifying input
`timescale 1ns/1ps
`default_nettype none

module legacyDemodTop (
    input  wire                                          clk,
    input  wire                                          clockCounterEn,
    input  wire                                          regReq,
    input  wire                                          regWrite,
    input  wire  [demodRegPkg::regAddrWidth-1:0]         regAddr,
    input  wire  [demodRegPkg::regDataWidth-1:0]         regWrData,
    output logic [demodRegPkg::regDataWidth-1:0]         regRdData,
    output logic                                         regAck,
    input  wire  demodDataPkg::dacSample_t               legacyDacData [demodDataPkg::numDacs],
    input  wire  [demodDataPkg::numDacs-1:0]             legacyDacSync,
    input  wire  demodDataPkg::dacSample_t               multihDacData [demodDataPkg::numDacs],
    input  wire  [demodDataPkg::numDacs-1:0]             multihDacSync,
    input  wire  [demodDataPkg::numDacs-1:0]             multihDacEn,
    input  wire  [demodDataPkg::sampleWidth-1:0]         legacyTrellisI,
    input  wire  [demodDataPkg::sampleWidth-1:0]         legacyTrellisQ,
    input  wire                                          legacyTrellisSymEn,
    input  wire                                          legacySym2xEn,
    input  wire  [demodDataPkg::sampleWidth-1:0]         multihTrellisI,
    input  wire  [demodDataPkg::sampleWidth-1:0]         multihTrellisQ,
    input  wire                                          multihSymEn,
    input  wire                                          multihSym2xEn,
    input  wire                                          iBit,
    input  wire                                          qBit,
    input  wire                                          auBit,
    input  wire                                          iSymEn,
    input  wire                                          carrierLock,
    input  wire                                          multihLock,
    input  wire                                          bitsyncLock,
    output logic [demodRegPkg::modeWidth-1:0]            demodMode,
    output logic [demodDataPkg::numDacs-1:0]             dacSync,
    output logic [demodDataPkg::dacWidth-1:0]            dacD [demodDataPkg::numDacs],
    output logic [demodDataPkg::sampleWidth-1:0]         iTrellis,
    output logic [demodDataPkg::sampleWidth-1:0]         qTrellis,
    output logic                                         trellisSymEn,
    output logic                                         trellisSym2xEn,
    output logic                                         iData,
    output logic                                         qData,
    output logic                                         dataSymEn,
    output logic                                         dataSym2xEn,
    output logic                                         legacyBit,
    output logic                                         demodNLock,
    output logic                                         bsyncNLock
);

    // Selector to DAC channels
    demodDataPkg::dacSample_t               selDacData [demodDataPkg::numDacs];
    logic [demodDataPkg::numDacs-1:0]       selDacSync;

    // ******************************
    // Registers and output selection
    // ******************************
    regBlock regBlock_i (.*);

    outputSelect outputSelect_i (.*);

    // ******************************
    // DAC channels
    // ******************************
    for (genvar k = 0; k < demodDataPkg::numDacs; k++) begin : dacGen
        dacChannel dacChannel_i (
            .clk            (clk),
            .clockCounterEn (clockCounterEn),
            .sample         (selDacData[k]),
            .sampleSync     (selDacSync[k]),
            .dacSync        (dacSync[k]),
            .dacD           (dacD[k])
        );
    end

endmodule

`default_nettype wire

// File: legacyDemodTop_assert.sv
// Four-phase handshake checks on the register block, attached by bind
// Checks are off while clockCounterEn is high
`timescale 1ns/1ps
`default_nettype none

module legacyDemodTop_assert (
    input wire clk,
    input wire clockCounterEn,
    input wire regReq,
    input wire regAck
);

    // regAck only rises in answer to a request
    ackNeedsReq: assert property (@(posedge clk) disable iff (clockCounterEn)
        (!regAck && !regReq) |=> !regAck)
        else $error("regAck rose without regReq");

    ackHolds: assert property (@(posedge clk) disable iff (clockCounterEn)
        (regAck && regReq) |=> regAck)
        else $error("regAck dropped while regReq was high");

    // One cycle to release after the master lets go
    ackDrops: assert property (@(posedge clk) disable iff (clockCounterEn)
        (regAck && !regReq) |=> !regAck)
        else $error("regAck stayed high after regReq fell");

endmodule

bind regBlock legacyDemodTop_assert legacyDemodTop_assert_i (.*);

`default_nettype wire

// File: legacyDemodTop_tb.sv
// Random-stimulus testbench for the legacy demod output side, $urandom seed 15030
// Reference model tracks the mode, the selector registers and the DAC holds every cycle
`timescale 1ns/1ps
`default_nettype none

module legacyDemodTop_tb;

    localparam int numDacs = demodDataPkg::numDacs;
    localparam int sw = demodDataPkg::sampleWidth;
    // Tests take about 2600 cycles, so this limit is a little over twice that
    localparam int maxCycles = 6000;

    logic clk = 1'b0;
    logic clockCounterEn;
    logic regReq, regWrite;
    logic [demodRegPkg::regAddrWidth-1:0] regAddr;
    logic [demodRegPkg::regDataWidth-1:0] regWrData, regRdData;
    logic regAck;
    demodDataPkg::dacSample_t legacyDacData [numDacs];
    demodDataPkg::dacSample_t multihDacData [numDacs];
    logic [numDacs-1:0] legacyDacSync, multihDacSync, multihDacEn, dacSync;
    logic [sw-1:0] legacyTrellisI, legacyTrellisQ, multihTrellisI, multihTrellisQ;
    logic legacyTrellisSymEn, legacySym2xEn, multihSymEn, multihSym2xEn;
    logic iBit, qBit, auBit, iSymEn, carrierLock, multihLock, bitsyncLock;
    logic [demodRegPkg::modeWidth-1:0] demodMode;
    logic [demodDataPkg::dacWidth-1:0] dacD [numDacs];
    logic [sw-1:0] iTrellis, qTrellis;
    logic trellisSymEn, trellisSym2xEn, iData, qData, dataSymEn, dataSym2xEn;
    logic legacyBit, demodNLock, bsyncNLock;

    // Reference model state
    logic [demodRegPkg::modeWidth-1:0] modelMode;
    logic modelMultih, modelFmGroup, modelAGroup;
    logic [numDacs-1:0] mSelSync, mDacSync;
    logic [sw-1:0] mSelWord [numDacs];
    logic [demodDataPkg::dacWidth-1:0] mDacD [numDacs];
    logic [sw-1:0] mITrellis, mQTrellis;
    logic mTSym, mTSym2x, mIData, mQData, mDSym, mDSym2x, mLegacyBit;
    logic mDemodNLock, mBsyncNLock;

    int cycleCount = 0;
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;

    legacyDemodTop legacyDemodTop_i (.*);

    always #5 clk = ~clk;

    // ******************************
    // Watchdog
    // ******************************
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: run passed %0d cycles without finishing", maxCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ******************************
    // Reference model
    // ******************************
    assign modelMultih  = (modelMode == demodRegPkg::modeMultih);
    assign modelFmGroup = (modelMode == demodRegPkg::modeFm) ||
                          (modelMode == demodRegPkg::mode2Fsk);
    assign modelAGroup  = (modelMode == demodRegPkg::modeAqpsk) ||
                          (modelMode == demodRegPkg::modeAuqpsk);

    always @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            mSelSync <= '0;
            mDacSync <= '0;
            for (int k = 0; k < numDacs; k++) begin
                mDacD[k] <= '0;
            end
            mITrellis <= '0;
            mQTrellis <= '0;
            {mTSym, mTSym2x, mIData, mQData, mDSym, mDSym2x, mLegacyBit} <= '0;
            mDemodNLock <= 1'b1;
            mBsyncNLock <= 1'b1;
        end else begin
            // DAC stage works on last cycle's selection
            mDacSync <= mSelSync;
            for (int k = 0; k < numDacs; k++) begin
                if (mSelSync[k]) mDacD[k] <= mSelWord[k][sw-1 -: demodDataPkg::dacWidth];
                mSelSync[k] <= (modelMultih && multihDacEn[k]) ? multihDacSync[k]
                                                               : legacyDacSync[k];
                mSelWord[k] <= (modelMultih && multihDacEn[k]) ? multihDacData[k]
                                                               : legacyDacData[k];
            end
            mITrellis   <= modelMultih ? multihTrellisI : legacyTrellisI;
            mQTrellis   <= modelMultih ? multihTrellisQ : legacyTrellisQ;
            mTSym       <= modelMultih ? multihSymEn : legacyTrellisSymEn;
            mTSym2x     <= modelMultih ? multihSym2xEn : legacySym2xEn;
            mIData      <= modelFmGroup ? !iBit : iBit;
            mQData      <= modelAGroup ? auBit : qBit;
            mDSym       <= iSymEn;
            mDSym2x     <= legacySym2xEn;
            mLegacyBit  <= iBit;
            mDemodNLock <= modelMultih ? !multihLock : !carrierLock;
            mBsyncNLock <= !bitsyncLock;
        end
    end

    task automatic logError(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Error at %0d ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        errorCount++;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // Four-phase access, returns read data and the cycle of the accepting edge
    task automatic regAccess(input logic wr, input logic [3:0] addr, input logic [15:0] wrData,
                             output logic [15:0] rdData, output int acceptCycle);
        int waitCycles;
        waitCycles = 0;
        @(posedge clk);
        regReq    <= 1'b1;
        regWrite  <= wr;
        regAddr   <= addr;
        regWrData <= wrData;
        do begin
            @(posedge clk);
            #1;
            waitCycles++;
        end while (!regAck);
        rdData = regRdData;
        acceptCycle = cycleCount;
        if (waitCycles != 1) logError("regAck latency", waitCycles, 1);
        if (wr && addr == demodRegPkg::addrMode) modelMode = wrData[4:0];
        @(posedge clk);
        regReq <= 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (regAck);
    endtask

    task automatic driveRandomInputs();
        for (int k = 0; k < numDacs; k++) begin
            legacyDacData[k] <= 18'($urandom);
            multihDacData[k] <= 18'($urandom);
        end
        legacyDacSync  <= 3'($urandom);
        multihDacSync  <= 3'($urandom);
        multihDacEn    <= 3'($urandom);
        legacyTrellisI <= 18'($urandom);
        legacyTrellisQ <= 18'($urandom);
        multihTrellisI <= 18'($urandom);
        multihTrellisQ <= 18'($urandom);
        {legacyTrellisSymEn, legacySym2xEn, multihSymEn, multihSym2xEn, iBit, qBit, auBit,
         iSymEn, carrierLock, multihLock, bitsyncLock} <= 11'($urandom);
    endtask

    task automatic runStreams(input logic [4:0] mode, input int cycles, input logic checkDac);
        logic [15:0] rdData;
        int acceptCycle;
        regAccess(1'b1, demodRegPkg::addrMode, {11'd0, mode}, rdData, acceptCycle);
        if (demodMode !== mode) logError("demodMode", demodMode, mode);
        repeat (cycles) begin
            @(posedge clk);
            driveRandomInputs();
            #1;
            if (checkDac) begin
                for (int k = 0; k < numDacs; k++) begin
                    if (dacSync[k] !== mDacSync[k]) logError("dacSync", dacSync[k], mDacSync[k]);
                    if (dacD[k] !== mDacD[k]) logError("dacD", dacD[k], mDacD[k]);
                end
            end else begin
                if (iTrellis !== mITrellis) logError("iTrellis", iTrellis, mITrellis);
                if (qTrellis !== mQTrellis) logError("qTrellis", qTrellis, mQTrellis);
                if (trellisSymEn !== mTSym) logError("trellisSymEn", trellisSymEn, mTSym);
                if (trellisSym2xEn !== mTSym2x) logError("trellisSym2xEn", trellisSym2xEn, mTSym2x);
                if (iData !== mIData) logError("iData", iData, mIData);
                if (qData !== mQData) logError("qData", qData, mQData);
                if (dataSymEn !== mDSym) logError("dataSymEn", dataSymEn, mDSym);
                if (dataSym2xEn !== mDSym2x) logError("dataSym2xEn", dataSym2xEn, mDSym2x);
                if (legacyBit !== mLegacyBit) logError("legacyBit", legacyBit, mLegacyBit);
                if (demodNLock !== mDemodNLock) logError("demodNLock", demodNLock, mDemodNLock);
                if (bsyncNLock !== mBsyncNLock) logError("bsyncNLock", bsyncNLock, mBsyncNLock);
            end
        end
    endtask

    // ******************************
    // Test sequence
    // ******************************
    initial begin
        logic [15:0] rd, lo, hi, data;
        int startErrors, wrEdge, rdEdge, unused;
        logic [31:0] expCount;
        logic [8:0] bitOutputs;
        clockCounterEn = 1'b1;
        regReq = 1'b0;
        regWrite = 1'b0;
        regAddr = '0;
        regWrData = '0;
        for (int k = 0; k < numDacs; k++) begin
            legacyDacData[k] = '0;
            multihDacData[k] = '0;
        end
        {legacyDacSync, multihDacSync, multihDacEn} = '0;
        {legacyTrellisI, legacyTrellisQ, multihTrellisI, multihTrellisQ} = '0;
        {legacyTrellisSymEn, legacySym2xEn, multihSymEn, multihSym2xEn} = '0;
        {iBit, qBit, auBit, iSymEn, carrierLock, multihLock, bitsyncLock} = '0;
        modelMode = demodRegPkg::modeAm;
        void'($urandom(15030));
        repeat (4) @(posedge clk);
        clockCounterEn <= 1'b0;
        #1;

        // Reset values and identification registers
        startErrors = errorCount;
        if (regAck !== 1'b0) logError("regAck", regAck, 0);
        if (demodMode !== demodRegPkg::modeAm) logError("demodMode", demodMode, 0);
        if (dacSync !== '0) logError("dacSync", dacSync, 0);
        for (int k = 0; k < numDacs; k++) begin
            if (dacD[k] !== '0) logError("dacD", dacD[k], 0);
        end
        if (iTrellis !== '0) logError("iTrellis", iTrellis, 0);
        if (qTrellis !== '0) logError("qTrellis", qTrellis, 0);
        // Only the two lock outputs come out of reset high
        bitOutputs = {trellisSymEn, trellisSym2xEn, iData, qData, dataSymEn, dataSym2xEn,
                      legacyBit, demodNLock, bsyncNLock};
        if (bitOutputs !== 9'b000000011) logError("bit outputs", bitOutputs, 9'b000000011);
        regAccess(1'b0, demodRegPkg::addrVersion, 16'h0, rd, unused);
        if (rd !== demodRegPkg::versionNumber) logError("regRdData", rd, 16'h0194);
        regAccess(1'b0, demodRegPkg::addrImageType, 16'h0, rd, unused);
        if (rd !== demodRegPkg::legacyDemodImage) logError("regRdData", rd, 16'h0003);
        regAccess(1'b0, 4'd9, 16'h0, rd, unused);
        if (rd !== 16'h0) logError("regRdData", rd, 0);
        finishTest("reset values and identification reads", startErrors);

        // Mode register keeps only its low bits
        startErrors = errorCount;
        repeat (20) begin
            data = 16'($urandom);
            regAccess(1'b1, demodRegPkg::addrMode, data, rd, unused);
            regAccess(1'b0, demodRegPkg::addrMode, 16'h0, rd, unused);
            if (rd !== {11'd0, data[4:0]}) logError("regRdData", rd, {11'd0, data[4:0]});
            if (demodMode !== data[4:0]) logError("demodMode", demodMode, data[4:0]);
        end
        finishTest("mode register write and read back", startErrors);

        // Counter value is the edges strictly between clear and read
        startErrors = errorCount;
        repeat (4) begin
            regAccess(1'b1, demodRegPkg::addrClockLo, 16'h0, rd, wrEdge);
            repeat ($urandom_range(200, 5)) @(posedge clk);
            regAccess(1'b0, demodRegPkg::addrClockLo, 16'h0, lo, rdEdge);
            regAccess(1'b0, demodRegPkg::addrClockHi, 16'h0, hi, unused);
            expCount = rdEdge - wrEdge - 1;
            if ({hi, lo} !== expCount) logError("clock counter", {hi, lo}, expCount);
        end
        finishTest("clock counter clear and read hold", startErrors);

        startErrors = errorCount;
        for (int m = 0; m <= 5; m++) begin
            runStreams(5'(m), 150, 1'b1);
        end
        finishTest("DAC channel selection and hold", startErrors);

        startErrors = errorCount;
        for (int m = 0; m <= 5; m++) begin
            runStreams(5'(m), 150, 1'b0);
        end
        finishTest("trellis, data bit and lock selection", startErrors);

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: legacyDemodTop.f
demodRegPkg.sv
demodDataPkg.sv
dacChannel.sv
regBlock.sv
outputSelect.sv
legacyDemodTop.sv
legacyDemodTop_assert.sv
legacyDemodTop_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = legacyDemodTop_tb
FILELIST  = legacyDemodTop.f
LOG       = simulate.log
FAILMSG   = Simulation failed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAILMSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAILMSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
